//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_audio_pkt
RTL_TOP    := audio_pkt_top
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES := $(wildcard source/*.sv verif/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
source/audio_pkt_pkg.sv
source/sample_packer.sv
source/pkt_fifo.sv
source/pkt_framer.sv
source/apb_pkt_regs.sv
source/audio_pkt_top.sv
verif/tb_audio_pkt.sv

//--- source/apb_pkt_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_pkt_regs
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  wire logic                   audio_clk,
    input  wire logic                   rst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [3:0]             paddr,
    input  wire logic [31:0]            pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  wire logic [7:0]             level,
    input  wire logic                   overflow,
    output audio_pkt_pkg::pkt_cfg_t     cfg
);

    audio_pkt_pkg::pkt_status_t status;

    logic access;
    logic wr_en;
    logic addr_ok;
    logic len_bad;

    assign access = psel && penable;
    assign wr_en  = access && pwrite && !pslverr;
    assign pready = 1'b1;   // zero wait states

    always_comb
    begin
        case (paddr)
            audio_pkt_pkg::REG_CTRL,
            audio_pkt_pkg::REG_PKT_WORDS,
            audio_pkt_pkg::REG_FIFO_LEVEL,
            audio_pkt_pkg::REG_OVERFLOW: addr_ok = 1'b1;
            default:                     addr_ok = 1'b0;
        endcase
    end

    assign len_bad = pwrite && (paddr == audio_pkt_pkg::REG_PKT_WORDS) &&
                     ((pwdata == 32'd0) || (pwdata > 32'(FIFO_DEPTH)));
    assign pslverr = access && (!addr_ok || len_bad);

    always_ff @(posedge audio_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg.transfer_enable <= 1'b0;
            cfg.pkt_words       <= audio_pkt_pkg::PKT_WORDS_RESET;
        end
        else if (wr_en && paddr == audio_pkt_pkg::REG_CTRL)
        begin
            cfg.transfer_enable <= pwdata[0];
        end
        else if (wr_en && paddr == audio_pkt_pkg::REG_PKT_WORDS)
        begin
            cfg.pkt_words <= pwdata[7:0];
        end
    end

    always_ff @(posedge audio_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status <= '0;
        end
        else
        begin
            status.level <= level;
            if (wr_en && paddr == audio_pkt_pkg::REG_OVERFLOW)
            begin
                status.overflow_count <= 16'd0;   // any write clears
            end
            else if (overflow && status.overflow_count != 16'hFFFF)
            begin
                status.overflow_count <= status.overflow_count + 16'd1;
            end
        end
    end

    always_comb
    begin
        case (paddr)
            audio_pkt_pkg::REG_CTRL:       prdata = {31'd0, cfg.transfer_enable};
            audio_pkt_pkg::REG_PKT_WORDS:  prdata = {24'd0, cfg.pkt_words};
            audio_pkt_pkg::REG_FIFO_LEVEL: prdata = {24'd0, status.level};
            audio_pkt_pkg::REG_OVERFLOW:   prdata = {16'd0, status.overflow_count};
            default:                       prdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/audio_pkt_pkg.sv
`default_nettype none

package audio_pkt_pkg;

    // one FIFO word holding two consecutive samples
    typedef struct packed {
        logic [15:0] first_sample;   // earlier sample of the pair
        logic [15:0] second_sample;
    } pcm_word_t;

    // status seen by the register block
    typedef struct packed {
        logic [7:0]  level;          // words in FIFO
        logic [15:0] overflow_count; // saturating drop count
    } pkt_status_t;

    // software controls
    typedef struct packed {
        logic       transfer_enable;
        logic [7:0] pkt_words;       // words per UDP packet
    } pkt_cfg_t;

    localparam logic [3:0] REG_CTRL       = 4'h0;
    localparam logic [3:0] REG_PKT_WORDS  = 4'h4;
    localparam logic [3:0] REG_FIFO_LEVEL = 4'h8;
    localparam logic [3:0] REG_OVERFLOW   = 4'hC;

    localparam logic [7:0] PKT_WORDS_RESET = 8'd16;

endpackage

`default_nettype wire

//--- source/audio_pkt_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_pkt_top
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  wire logic          audio_clk,
    input  wire logic          rst_n,
    input  wire logic          audio_en,
    input  wire logic [15:0]   audio_data,
    input  wire logic          psel,
    input  wire logic          penable,
    input  wire logic          pwrite,
    input  wire logic [3:0]    paddr,
    input  wire logic [31:0]   pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  wire logic          udp_tx_req,
    input  wire logic          udp_tx_done,
    output logic               udp_tx_start_en,
    output logic [31:0]        udp_tx_data,
    output logic [15:0]        udp_tx_byte_num
);

    audio_pkt_pkg::pkt_cfg_t  cfg;
    audio_pkt_pkg::pcm_word_t word;
    audio_pkt_pkg::pcm_word_t rd_word;
    logic                     word_valid;
    logic                     pop;
    logic [7:0]               level;
    logic                     overflow;

    sample_packer u_packer
    (
        .audio_clk       (audio_clk),
        .rst_n           (rst_n),
        .audio_en        (audio_en),
        .audio_data      (audio_data),
        .transfer_enable (cfg.transfer_enable),
        .word_valid      (word_valid),
        .word            (word)
    );

    pkt_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .audio_clk  (audio_clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word       (word),
        .pop        (pop),
        .rd_word    (rd_word),
        .level      (level),
        .overflow   (overflow)
    );

    pkt_framer u_framer
    (
        .audio_clk       (audio_clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .level           (level),
        .rd_word         (rd_word),
        .pop             (pop),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .udp_tx_start_en (udp_tx_start_en),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_byte_num (udp_tx_byte_num)
    );

    apb_pkt_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs
    (
        .audio_clk (audio_clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .level     (level),
        .overflow  (overflow),
        .cfg       (cfg)
    );

endmodule

`default_nettype wire

//--- source/pkt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  wire logic                       audio_clk,
    input  wire logic                       rst_n,
    input  wire logic                       word_valid,
    input  wire audio_pkt_pkg::pcm_word_t   word,
    input  wire logic                       pop,
    output audio_pkt_pkg::pcm_word_t        rd_word,
    output logic [7:0]                      level,
    output logic                            overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    audio_pkt_pkg::pcm_word_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             wr_en;

    assign full     = (level == 8'(FIFO_DEPTH));
    assign wr_en    = word_valid && !full;
    assign overflow = word_valid && full;   // word is lost

    always_ff @(posedge audio_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= word;
        end
    end

    always_ff @(posedge audio_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= 8'd0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps since depth is a power of two
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   level <= level + 8'd1;
                2'b01:   level <= level - 8'd1;
                default: level <= level;
            endcase
        end
    end

    assign rd_word = mem[rd_ptr];

    a_no_pop_empty: assert property (
        @(posedge audio_clk) disable iff (!rst_n)
        pop |-> (level != 8'd0)
    ) else $error("pop from empty FIFO");

endmodule

`default_nettype wire

//--- source/pkt_framer.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_framer
(
    input  wire logic                       audio_clk,
    input  wire logic                       rst_n,
    input  wire audio_pkt_pkg::pkt_cfg_t    cfg,
    input  wire logic [7:0]                 level,
    input  wire audio_pkt_pkg::pcm_word_t   rd_word,
    output logic                            pop,
    input  wire logic                       udp_tx_req,
    input  wire logic                       udp_tx_done,
    output logic                            udp_tx_start_en,
    output logic [31:0]                     udp_tx_data,
    output logic [15:0]                     udp_tx_byte_num
);

    typedef enum logic [1:0]
    {
        IDLE,
        ANNOUNCE,
        STREAM
    } state_t;

    state_t     state;
    logic [7:0] words_q;   // packet length, fixed for the packet
    logic [7:0] req_cnt;   // words handed out so far
    logic       ready;

    assign ready = cfg.transfer_enable && (level >= cfg.pkt_words);

    assign udp_tx_start_en = (state == ANNOUNCE);
    assign pop             = (state == STREAM) && udp_tx_req && (req_cnt != words_q);
    assign udp_tx_byte_num = {6'd0, words_q, 2'b00};

    always_ff @(posedge audio_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            words_q <= 8'd0;
            req_cnt <= 8'd0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (ready)
                    begin
                        state   <= ANNOUNCE;
                        words_q <= cfg.pkt_words;
                        req_cnt <= 8'd0;
                    end
                end
                ANNOUNCE:
                begin
                    state <= STREAM;   // start_en lasts one cycle
                end
                STREAM:
                begin
                    if (pop)
                    begin
                        req_cnt <= req_cnt + 8'd1;
                    end
                    if (udp_tx_done)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // data follows the request by one cycle
    always_ff @(posedge audio_clk)
    begin
        if (pop)
        begin
            udp_tx_data <= rd_word;
        end
    end

    // the UDP core must not ask for more words than announced
    a_req_in_budget: assert property (
        @(posedge audio_clk) disable iff (!rst_n)
        (state == STREAM && udp_tx_req) |-> (req_cnt < words_q)
    ) else $error("udp_tx_req beyond packet length %0d", words_q);

endmodule

`default_nettype wire

//--- source/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_packer
(
    input  wire logic                 audio_clk,
    input  wire logic                 rst_n,
    input  wire logic                 audio_en,
    input  wire logic [15:0]          audio_data,
    input  wire logic                 transfer_enable,
    output logic                      word_valid,
    output audio_pkt_pkg::pcm_word_t  word
);

    logic        phase;       // first half of a pair is held
    logic        pair_ready;
    logic [15:0] first_q;
    logic        take;

    assign take = audio_en && transfer_enable;

    always_ff @(posedge audio_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase      <= 1'b0;
            pair_ready <= 1'b0;
        end
        else if (!transfer_enable)
        begin
            phase      <= 1'b0;   // drop half-filled pair
            pair_ready <= 1'b0;
        end
        else
        begin
            pair_ready <= take && phase;
            if (take)
            begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge audio_clk)
    begin
        if (take && !phase)
        begin
            first_q <= audio_data;
        end
        if (take && phase)
        begin
            word.first_sample  <= first_q;
            word.second_sample <= audio_data;
        end
    end

    assign word_valid = pair_ready && transfer_enable;

    // a word only follows a sample taken while enabled, and never leaks after disable
    a_valid_needs_enable: assert property (
        @(posedge audio_clk) disable iff (!rst_n)
        word_valid |-> (transfer_enable && $past(take && phase))
    ) else $error("word_valid without transfer_enable");

endmodule

`default_nettype wire

//--- verif/tb_audio_pkt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_audio_pkt;

    localparam int FIFO_DEPTH = 64;
    localparam int NUM_ROWS   = 4;

    typedef struct packed {
        int          words;      // pkt_words for the row
        int          packets;
        logic [15:0] first;      // first sample value
        logic [15:0] step;
        logic        silent;     // requester ignores start_en
    } row_t;

    // the silent row leaves the framer waiting, so it stays last
    row_t rows [NUM_ROWS] = '{
        '{8,  3, 16'h1000, 16'h0001, 1'b0},
        '{4,  4, 16'hFFF0, 16'h0003, 1'b0},
        '{32, 2, 16'h8000, 16'h0101, 1'b0},
        '{16, 5, 16'h0000, 16'h0010, 1'b1}
    };

    logic        audio_clk;
    logic        rst_n;
    logic        audio_en;
    logic [15:0] audio_data;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        udp_tx_req;
    logic        udp_tx_done;
    logic        udp_tx_start_en;
    logic [31:0] udp_tx_data;
    logic [15:0] udp_tx_byte_num;

    audio_pkt_pkg::pcm_word_t exp_q [$];   // words still owed by the DUT
    int   cur_words;
    int   pkt_count;
    logic silent;
    logic start_forbidden;
    logic cfg_busy;                        // holds done back during a length change
    int   data_errs;
    int   ctrl_errs;
    int   apb_errs;

    audio_pkt_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT
    (
        .audio_clk       (audio_clk),
        .rst_n           (rst_n),
        .audio_en        (audio_en),
        .audio_data      (audio_data),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .udp_tx_start_en (udp_tx_start_en),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_byte_num (udp_tx_byte_num)
    );

    initial
    begin
        audio_clk = 1'b0;
        forever #4 audio_clk = ~audio_clk;
    end

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge audio_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge audio_clk);
        penable <= 1'b1;
        @(negedge audio_clk);   // access phase
        rdata = prdata;
        err   = pslverr;
        assert (pready)
        else
        begin
            $display("FAILED pready: got %h expected %h", pready, 1'b1);
            apb_errs++;
        end
        @(posedge audio_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_status(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(wr, addr, wdata, rdata, err);
        assert (err == exp_err)
        else
        begin
            $display("FAILED pslverr: addr %h got %h expected %h", addr, err, exp_err);
            apb_errs++;
        end
    endtask

    task automatic reg_check(input logic [3:0] addr, input logic [31:0] exp_data,
                             input string name);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rdata, err);
        assert (!err && rdata == exp_data)
        else
        begin
            $display("FAILED %s: got %h expected %h pslverr %h", name, rdata, exp_data, err);
            apb_errs++;
        end
    endtask

    task automatic send_samples(input int count, input logic [15:0] first,
                                input logic [15:0] step, input logic record);
        logic [15:0]              s;
        logic [15:0]              prev;
        audio_pkt_pkg::pcm_word_t w;
        int                       gap;
        s    = first;
        prev = first;
        for (int j = 0; j < count; j++)
        begin
            gap = $urandom_range(3, 0);
            repeat (gap)
            begin
                @(posedge audio_clk);
                audio_en <= 1'b0;
            end
            @(posedge audio_clk);
            audio_en   <= 1'b1;
            audio_data <= s;
            if (record && j % 2 == 1)
            begin
                w.first_sample  = prev;   // earlier sample goes high
                w.second_sample = s;
                exp_q.push_back(w);
            end
            prev = s;
            s    = s + step;
        end
        @(posedge audio_clk);
        audio_en <= 1'b0;
    endtask

    // UDP core model issuing one request per word then done
    task automatic serve_packet(input int n);
        int                       gap;
        audio_pkt_pkg::pcm_word_t want;
        for (int i = 0; i < n; i++)
        begin
            gap = $urandom_range(2, 0);
            repeat (gap) @(posedge audio_clk);
            @(posedge audio_clk);
            udp_tx_req <= 1'b1;
            @(posedge audio_clk);
            udp_tx_req <= 1'b0;
            @(negedge audio_clk);   // word follows the request cycle
            if (exp_q.size() == 0)
            begin
                $display("data word arrived with no expected word left");
                data_errs++;
            end
            else
            begin
                want = exp_q.pop_front();
                assert (udp_tx_data == want)
                else
                begin
                    $display("FAILED udp_tx_data: got %h expected %h", udp_tx_data, want);
                    data_errs++;
                end
            end
            assert (udp_tx_byte_num == 16'(cur_words * 4))
            else
            begin
                $display("FAILED udp_tx_byte_num: got %h expected %h", udp_tx_byte_num,
                         16'(cur_words * 4));
                ctrl_errs++;
            end
        end
        wait (!cfg_busy);
        @(posedge audio_clk);
        udp_tx_done <= 1'b1;
        @(posedge audio_clk);
        udp_tx_done <= 1'b0;
        pkt_count++;
    endtask

    initial
    begin : requester
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge audio_clk);
            if (udp_tx_start_en)
            begin
                assert (!start_forbidden)
                else
                begin
                    $display("udp_tx_start_en pulsed while transfer was disabled");
                    ctrl_errs++;
                end
                assert (udp_tx_byte_num == 16'(cur_words * 4))
                else
                begin
                    $display("FAILED udp_tx_byte_num: got %h expected %h", udp_tx_byte_num,
                             16'(cur_words * 4));
                    ctrl_errs++;
                end
                if (!silent)
                begin
                    serve_packet(int'(udp_tx_byte_num[15:2]));
                end
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        limit = 10000;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            limit += rows[r].packets * rows[r].words * 64;
        end
        repeat (limit) @(posedge audio_clk);
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin : main
        int target;
        int k;
        void'($urandom(32'h2625));
        rst_n           = 1'b0;
        audio_en        = 1'b0;
        audio_data      = 16'd0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = 4'd0;
        pwdata          = 32'd0;
        udp_tx_req      = 1'b0;
        udp_tx_done     = 1'b0;
        cur_words       = 16;
        pkt_count       = 0;
        silent          = 1'b0;
        start_forbidden = 1'b0;
        cfg_busy        = 1'b0;
        data_errs       = 0;
        ctrl_errs       = 0;
        apb_errs        = 0;
        target          = 0;
        repeat (16) @(posedge audio_clk);
        rst_n <= 1'b1;

        // bad lengths and unmapped address
        reg_check(audio_pkt_pkg::REG_PKT_WORDS, 32'd16, "pkt_words");
        apb_status(1'b1, audio_pkt_pkg::REG_PKT_WORDS, 32'd0, 1'b1);
        apb_status(1'b1, audio_pkt_pkg::REG_PKT_WORDS, 32'(FIFO_DEPTH + 1), 1'b1);
        apb_status(1'b0, 4'h2, 32'd0, 1'b1);
        reg_check(audio_pkt_pkg::REG_PKT_WORDS, 32'd16, "pkt_words");

        start_forbidden = 1'b1;   // transfer still off after reset
        send_samples(40, 16'h5555, 16'h0001, 1'b0);
        repeat (4) @(posedge audio_clk);
        reg_check(audio_pkt_pkg::REG_FIFO_LEVEL, 32'd0, "fifo_level");
        start_forbidden = 1'b0;

        apb_status(1'b1, audio_pkt_pkg::REG_CTRL, 32'd1, 1'b0);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            apb_status(1'b1, audio_pkt_pkg::REG_PKT_WORDS, 32'(rows[r].words), 1'b0);
            cur_words = rows[r].words;
            silent    = rows[r].silent;
            cfg_busy  = (r == 0);
            fork
                send_samples(2 * rows[r].words * rows[r].packets, rows[r].first,
                             rows[r].step, 1'b1);
                begin
                    if (r == 0)
                    begin
                        do @(negedge audio_clk); while (!udp_tx_start_en);
                        apb_status(1'b1, audio_pkt_pkg::REG_PKT_WORDS, 32'd3, 1'b0);
                        apb_status(1'b1, audio_pkt_pkg::REG_PKT_WORDS, 32'(rows[r].words),
                                   1'b0);
                        cfg_busy = 1'b0;
                    end
                end
            join
            if (!rows[r].silent)
            begin
                target += rows[r].packets;
                wait (pkt_count == target);
                assert (exp_q.size() == 0)
                else
                begin
                    $display("%0d expected words were never delivered", exp_q.size());
                    data_errs++;
                end
            end
            else
            begin
                k = rows[r].words * rows[r].packets - FIFO_DEPTH;   // dropped words
                repeat (4) @(posedge audio_clk);
                reg_check(audio_pkt_pkg::REG_FIFO_LEVEL, 32'(FIFO_DEPTH), "fifo_level");
                reg_check(audio_pkt_pkg::REG_OVERFLOW, 32'(k), "overflow_count");
                apb_status(1'b1, audio_pkt_pkg::REG_OVERFLOW, 32'd0, 1'b0);
                reg_check(audio_pkt_pkg::REG_OVERFLOW, 32'd0, "overflow_count");
            end
        end

        repeat (8) @(posedge audio_clk);
        $display("errors: data %0d, control %0d, apb %0d", data_errs, ctrl_errs, apb_errs);
        if (data_errs + ctrl_errs + apb_errs == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
